/* gpio_lite.f */
+incdir+test
logic/gpio_pin_pkg.sv
logic/gpio_regmap_pkg.sv
logic/gpio_lite_apb_unit.sv
logic/gpio_lite_subunit.sv
logic/gpio_lite.sv
test/gpio_lite_tb.sv

/* logic/gpio_lite.sv */
/*
  gpio_lite top level, 16 pin gpio on apb
  apb slave unit feeding the pin register block
*/
module gpio_lite
  import gpio_pin_pkg::*;
  import gpio_regmap_pkg::*;
(
  input  logic       pclk18,
  input  logic       n_reset18,
  // apb slave port
  input  logic       psel,
  input  logic       penable,
  input  logic       pwrite,
  input  gpio_addr_t paddr,
  input  apb_data_t  pwdata,
  output apb_data_t  prdata,
  output logic       pslverr,
  // pads
  input  gpio_pins_t pin_in,
  input  gpio_pins_t tri_state_enable,  // dft tristate
  output gpio_pins_t pin_out,
  output gpio_pins_t pin_oe_n,
  output logic       irq                // any status bit set
);

  // strobes between the apb unit and the registers
  logic       sub_read;
  logic       sub_write;
  gpio_addr_t sub_addr;
  gpio_pins_t sub_wdata;
  gpio_pins_t sub_rdata;
  gpio_pins_t sub_interrupt;  // per pin status

  gpio_lite_apb_unit apb_unit_i (
    .pclk18    (pclk18),
    .n_reset18 (n_reset18),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .rdata     (sub_rdata),
    .interrupt (sub_interrupt),
    .prdata    (prdata),
    .pslverr   (pslverr),
    .irq       (irq),
    .read      (sub_read),
    .write     (sub_write),
    .addr      (sub_addr),
    .wdata     (sub_wdata)
  );

  gpio_lite_subunit subunit_i (
    .pclk18           (pclk18),
    .n_reset18        (n_reset18),
    .read             (sub_read),
    .write            (sub_write),
    .addr             (sub_addr),
    .wdata            (sub_wdata),
    .pin_in           (pin_in),
    .tri_state_enable (tri_state_enable),
    .interrupt        (sub_interrupt),
    .rdata            (sub_rdata),
    .pin_oe_n         (pin_oe_n),
    .pin_out          (pin_out)
  );

endmodule

/* logic/gpio_lite_apb_unit.sv */
/*
  apb slave front end of gpio_lite, zero wait states
  turns transfers into read / write strobes for the register block,
  flags unmapped or read-only accesses and merges the irq vector
*/
module gpio_lite_apb_unit
  import gpio_pin_pkg::*;
  import gpio_regmap_pkg::*;
(
  input  logic       pclk18,
  input  logic       n_reset18,
  input  logic       psel,
  input  logic       penable,
  input  logic       pwrite,
  input  gpio_addr_t paddr,
  input  apb_data_t  pwdata,
  input  gpio_pins_t rdata,      // registered read data from subunit
  input  gpio_pins_t interrupt,  // per pin status
  output apb_data_t  prdata,
  output logic       pslverr,
  output logic       irq,
  output logic       read,
  output logic       write,
  output gpio_addr_t addr,
  output gpio_pins_t wdata
);

  logic setup_phase;   // psel, no penable
  logic access_phase;  // second and last cycle
  logic addr_rd_ok;
  logic addr_wr_ok;
  logic xfer_err;      // illegal for this direction

  // --------------------
  // transfer classification
  assign setup_phase  = psel & ~penable;
  assign access_phase = psel & penable;
  assign addr_rd_ok   = gpio_reg_readable(paddr);
  assign addr_wr_ok   = gpio_reg_writable(paddr);
  assign xfer_err     = pwrite ? ~addr_wr_ok : ~addr_rd_ok;  // unmapped or read-only

  // strobes, legal transfers only
  assign read  = setup_phase & ~pwrite & addr_rd_ok;   // data ready for access cycle
  assign write = access_phase & pwrite & addr_wr_ok;   // lands at end of access
  assign addr  = paddr;
  assign wdata = pwdata[GPIO_WIDTH-1:0];               // upper bus bits ignored

  assign prdata = {{(APB_DATA_WIDTH - GPIO_WIDTH){1'b0}}, rdata};  // zero extend

  // --------------------
  // error and irq flops
  always_ff @(posedge pclk18 or negedge n_reset18)
  begin
    if (!n_reset18)
    begin
      pslverr <= 1'b0;
      irq     <= 1'b0;
    end
    else
    begin
      pslverr <= setup_phase & xfer_err;  // high across the access cycle only
      irq     <= |interrupt;              // any pending edge
    end
  end

  // master holds psel through both phases
  a_penable_has_psel: assert property (@(posedge pclk18) disable iff (!n_reset18)
    penable |-> psel);

endmodule

/* logic/gpio_lite_subunit.sv */
/*
  gpio_lite register block, one bit per pin
  direction, enable and value registers written on the write strobe,
  synchronized pin input with rising edge status, registered read data
*/
module gpio_lite_subunit
  import gpio_pin_pkg::*;
  import gpio_regmap_pkg::*;
(
  input  logic       pclk18,
  input  logic       n_reset18,
  input  logic       read,              // setup cycle of a legal read
  input  logic       write,             // access cycle of a legal write
  input  gpio_addr_t addr,
  input  gpio_pins_t wdata,
  input  gpio_pins_t pin_in,            // async from pads
  input  gpio_pins_t tri_state_enable,  // dft, forces drivers off
  output gpio_pins_t interrupt,
  output gpio_pins_t rdata,
  output gpio_pins_t pin_oe_n,          // active low driver enable
  output gpio_pins_t pin_out
);

  // --------------------
  // register state
  // --------------------
  gpio_pins_t direction_mode;  // 1 = input, 0 = output
  gpio_pins_t output_enable;   // 1 = drive pin
  gpio_pins_t output_value;    // pin value when driven
  gpio_pins_t input_value;     // synchronized pin value
  gpio_pins_t int_status;      // sticky rising edge flags

  // metastability chain
  gpio_pins_t sync_one;  // first stage at the pads
  gpio_pins_t sync_two;  // settled, compared against input_value

  // interrupt control
  gpio_pins_t int_event;          // 0 -> 1 between sync_two and input_value
  gpio_pins_t interrupt_trigger;  // event on an input pin
  gpio_pins_t status_clear;       // status read in progress

  // exact address hits, class is checked upstream
  logic ad_direction_mode;
  logic ad_output_enable;
  logic ad_output_value;
  logic ad_int_status;

  assign ad_direction_mode = (addr == GPR_DIRECTION_MODE);
  assign ad_output_enable  = (addr == GPR_OUTPUT_ENABLE);
  assign ad_output_value   = (addr == GPR_OUTPUT_VALUE);
  assign ad_int_status     = (addr == GPR_INT_STATUS);

  // --------------------
  // config registers
  // --------------------
  always_ff @(posedge pclk18 or negedge n_reset18)
  begin
    if (!n_reset18)
    begin
      direction_mode <= GPRV_DIRECTION_MODE;
      output_enable  <= GPRV_OUTPUT_ENABLE;
      output_value   <= GPRV_OUTPUT_VALUE;
    end
    else if (write)
    begin
      if (ad_direction_mode)
        direction_mode <= wdata;
      if (ad_output_enable)
        output_enable <= wdata;
      if (ad_output_value)
        output_value <= wdata;
    end
  end

  // --------------------
  // input synchronizer
  // --------------------
  // pin_in visible in input_value on the third edge
  always_ff @(posedge pclk18 or negedge n_reset18)
  begin
    if (!n_reset18)
    begin
      sync_one    <= '0;
      sync_two    <= '0;
      input_value <= GPRV_INPUT_VALUE;
    end
    else
    begin
      sync_one    <= pin_in;
      sync_two    <= sync_one;
      input_value <= sync_two;  // also the edge detector history
    end
  end

  // --------------------
  // edge interrupt
  // --------------------
  assign int_event         = sync_two & ~input_value;      // rising edge
  assign interrupt_trigger = int_event & direction_mode;   // inputs only
  assign status_clear      = {GPIO_WIDTH{read & ad_int_status}};

  // set lands with input_value update, a new edge beats the clear
  always_ff @(posedge pclk18 or negedge n_reset18)
  begin
    if (!n_reset18)
      int_status <= GPRV_INT_STATUS;
    else
      int_status <= (int_status & ~status_clear) | interrupt_trigger;
  end

  assign interrupt = int_status;  // combined into irq by the apb unit

  // --------------------
  // read data
  // --------------------
  // captured in setup, held for the access cycle, zero otherwise
  always_ff @(posedge pclk18 or negedge n_reset18)
  begin
    if (!n_reset18)
      rdata <= '0;
    else if (read)
    begin
      case (addr)
        GPR_DIRECTION_MODE:
          rdata <= direction_mode;
        GPR_OUTPUT_ENABLE:
          rdata <= output_enable;
        GPR_OUTPUT_VALUE:
          rdata <= output_value;
        GPR_INPUT_VALUE:
          rdata <= input_value;
        GPR_INT_STATUS:
          rdata <= int_status;  // value before the clear
        default:
          rdata <= '0;
      endcase
    end
    else
      rdata <= '0;
  end

  // --------------------
  // pin drivers
  // --------------------
  assign pin_out = output_value;

  // driven only when enabled, set as output and not forced off
  assign pin_oe_n = ~(output_enable & ~direction_mode) | tri_state_enable;

  // setup and access strobes never coincide
  a_no_rd_wr_same_cycle: assert property (@(posedge pclk18) disable iff (!n_reset18)
    !(read && write));

endmodule

/* logic/gpio_pin_pkg.sv */
/*
  pin and bus data definitions for the gpio_lite peripheral
  imported by every block that carries pin, register or apb data
*/
package gpio_pin_pkg;

  // --------------------
  // widths
  // --------------------
  localparam int GPIO_WIDTH     = 16;  // pins per block
  localparam int APB_DATA_WIDTH = 32;  // apb pwdata / prdata

  // --------------------
  // vector types
  // --------------------

  // one bit per pin
  // pins, register contents and interrupt vector
  typedef logic [GPIO_WIDTH-1:0] gpio_pins_t;

  // full apb data word, upper bits unused by the registers
  typedef logic [APB_DATA_WIDTH-1:0] apb_data_t;

endpackage

/* logic/gpio_regmap_pkg.sv */
/*
  register map of gpio_lite with addresses, reset values and
  address class decode used by the apb slave
*/
package gpio_regmap_pkg;
  import gpio_pin_pkg::*;

  localparam int GPIO_ADDR_WIDTH = 6;                  // paddr bits seen by the block
  typedef logic [GPIO_ADDR_WIDTH-1:0] gpio_addr_t;

  // --------------------
  // register addresses
  localparam gpio_addr_t GPR_DIRECTION_MODE = 6'h04;  // 1 = input, rw
  localparam gpio_addr_t GPR_OUTPUT_ENABLE  = 6'h08;  // driver enable, rw
  localparam gpio_addr_t GPR_OUTPUT_VALUE   = 6'h0C;  // value to drive, rw
  localparam gpio_addr_t GPR_INPUT_VALUE    = 6'h10;  // synchronized pins, ro
  localparam gpio_addr_t GPR_INT_STATUS     = 6'h20;  // edge status, ro, clear on read

  // reset values
  localparam gpio_pins_t GPRV_DIRECTION_MODE = '0;  // all outputs
  localparam gpio_pins_t GPRV_OUTPUT_ENABLE  = '0;  // drivers off
  localparam gpio_pins_t GPRV_OUTPUT_VALUE   = '0;
  localparam gpio_pins_t GPRV_INPUT_VALUE    = '0;
  localparam gpio_pins_t GPRV_INT_STATUS     = '0;  // no pending edges

  function automatic logic gpio_reg_readable(gpio_addr_t a);
    return (a == GPR_DIRECTION_MODE) || (a == GPR_OUTPUT_ENABLE) ||
           (a == GPR_OUTPUT_VALUE) || (a == GPR_INPUT_VALUE) || (a == GPR_INT_STATUS);
  endfunction

  function automatic logic gpio_reg_writable(gpio_addr_t a);  // config regs only
    return (a == GPR_DIRECTION_MODE) || (a == GPR_OUTPUT_ENABLE) || (a == GPR_OUTPUT_VALUE);
  endfunction

endpackage

/* test/gpio_lite_tb_table.svh */
/*
  register transfer table for gpio_lite_tb, included inside the module
  rows run in order after reset with pin_in and tri_state_enable low
*/
`ifndef GPIO_LITE_TB_TABLE_SVH
`define GPIO_LITE_TB_TABLE_SVH

localparam int NUM_ROWS = 21;

// columns: op, address, write data, expected prdata (low 16 bits), expected pslverr
function automatic row_t table_row(input int i);
  case (i)
    0:  return {OP_RD, GPR_DIRECTION_MODE, 16'h0000, 16'h0000, 1'b0};  // reset values
    1:  return {OP_RD, GPR_OUTPUT_ENABLE,  16'h0000, 16'h0000, 1'b0};
    2:  return {OP_RD, GPR_OUTPUT_VALUE,   16'h0000, 16'h0000, 1'b0};
    3:  return {OP_RD, GPR_INPUT_VALUE,    16'h0000, 16'h0000, 1'b0};
    4:  return {OP_RD, GPR_INT_STATUS,     16'h0000, 16'h0000, 1'b0};
    5:  return {OP_WR, GPR_DIRECTION_MODE, 16'h00F0, 16'h0000, 1'b0};  // config writes
    6:  return {OP_WR, GPR_OUTPUT_ENABLE,  16'hFF0F, 16'h0000, 1'b0};
    7:  return {OP_WR, GPR_OUTPUT_VALUE,   16'hA5C3, 16'h0000, 1'b0};
    8:  return {OP_RD, GPR_DIRECTION_MODE, 16'h0000, 16'h00F0, 1'b0};  // readback
    9:  return {OP_RD, GPR_OUTPUT_ENABLE,  16'h0000, 16'hFF0F, 1'b0};
    10: return {OP_RD, GPR_OUTPUT_VALUE,   16'h0000, 16'hA5C3, 1'b0};
    11: return {OP_WR, GPR_INPUT_VALUE,    16'h1234, 16'h0000, 1'b1};  // read-only
    12: return {OP_WR, GPR_INT_STATUS,     16'hFFFF, 16'h0000, 1'b1};
    13: return {OP_WR, 6'h14,              16'hBEEF, 16'h0000, 1'b1};  // unmapped
    14: return {OP_RD, 6'h14,              16'h0000, 16'h0000, 1'b1};
    15: return {OP_RD, 6'h3C,              16'h0000, 16'h0000, 1'b1};
    16: return {OP_RD, GPR_DIRECTION_MODE, 16'h0000, 16'h00F0, 1'b0};  // nothing changed
    17: return {OP_RD, GPR_OUTPUT_ENABLE,  16'h0000, 16'hFF0F, 1'b0};
    18: return {OP_RD, GPR_OUTPUT_VALUE,   16'h0000, 16'hA5C3, 1'b0};
    19: return {OP_RD, GPR_INPUT_VALUE,    16'h0000, 16'h0000, 1'b0};
    default: return {OP_RD, GPR_INT_STATUS, 16'h0000, 16'h0000, 1'b0};
  endcase
endfunction

`endif

/* test/gpio_lite_tb.sv */
/*
  self-checking testbench for gpio_lite
  reset check, table of register transfers, then random pin rounds
*/
module gpio_lite_tb
  import gpio_pin_pkg::*;
  import gpio_regmap_pkg::*;
();

  localparam int   CLK_PERIOD = 100;
  localparam int   NUM_ROUNDS = 8;      // random pin rounds
  localparam logic OP_RD      = 1'b0;
  localparam logic OP_WR      = 1'b1;

  typedef struct packed {
    logic       wr;
    gpio_addr_t addr;
    gpio_pins_t wdata;
    gpio_pins_t exp_data;
    logic       exp_err;
  } row_t;

  `include "gpio_lite_tb_table.svh"

  localparam int WATCHDOG_CYCLES = (NUM_ROWS + NUM_ROUNDS) * 20;

  logic       pclk18, n_reset18, psel, penable, pwrite, pslverr, irq;
  gpio_addr_t paddr;
  apb_data_t  pwdata, prdata;
  gpio_pins_t pin_in, tri_state_enable, pin_out, pin_oe_n;
  int         errors, tests_run, tests_failed;
  logic [31:0] rng;  // xorshift state

  gpio_lite gpio_lite_i (.*);

  initial
  begin
    pclk18 = 1'b0;
    forever #(CLK_PERIOD/2) pclk18 = ~pclk18;
  end

  // --------------------
  // apb driver, one setup and one access cycle
  task automatic apb_write(input gpio_addr_t a, input gpio_pins_t d,
                           output apb_data_t rd, output logic err);
    @(negedge pclk18);
    psel = 1'b1;
    penable = 1'b0;
    pwrite = 1'b1;
    paddr = a;
    pwdata = apb_data_t'(d);
    @(negedge pclk18);
    rd = prdata;  // mid access cycle
    err = pslverr;
    penable = 1'b1;
    @(negedge pclk18);
    psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_read(input gpio_addr_t a, output apb_data_t rd, output logic err);
    @(negedge pclk18);
    psel = 1'b1;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = a;
    @(negedge pclk18);
    rd = prdata;
    err = pslverr;
    penable = 1'b1;
    @(negedge pclk18);
    psel = 1'b0;
    penable = 1'b0;
  endtask

  // --------------------
  // compare tasks
  task automatic check_data(input string what, input apb_data_t got, input apb_data_t exp);
    if (got !== exp)
    begin
      errors++;
      $display("[ERROR] %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
    end
  endtask

  task automatic check_pins(input string what, input gpio_pins_t got, input gpio_pins_t exp);
    if (got !== exp)
    begin
      errors++;
      $display("[ERROR] %0t: %s is 0x%04h, expected 0x%04h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp)
    begin
      errors++;
      $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // driver off unless enabled, output and not tristated
  function automatic gpio_pins_t oe_n_rule(gpio_pins_t dir, gpio_pins_t oe, gpio_pins_t tse);
    gpio_pins_t oe_n;
    for (int i = 0; i < GPIO_WIDTH; i++)
    begin
      if (oe[i] === 1'b1 && dir[i] === 1'b0 && tse[i] === 1'b0)
        oe_n[i] = 1'b0;  // pin driven
      else
        oe_n[i] = 1'b1;
    end
    return oe_n;
  endfunction

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  task automatic random_pins(output gpio_pins_t p);
    rng = xorshift32(rng);
    p = rng[23:8];
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (errors != errs_before)
    begin
      tests_failed++;
      $display("%s: fail", name);
    end
    else
      $display("%s: ok", name);
  endtask

  // legal transfer, no error expected
  task automatic write_ok(input gpio_addr_t a, input gpio_pins_t d);
    apb_data_t rd;
    logic      err;
    apb_write(a, d, rd, err);
    check_bit($sformatf("pslverr on write 0x%02h", a), err, 1'b0);
  endtask

  task automatic read_expect(input gpio_addr_t a, input gpio_pins_t exp);
    apb_data_t rd;
    logic      err;
    apb_read(a, rd, err);
    check_data($sformatf("read 0x%02h", a), rd, apb_data_t'(exp));
    check_bit($sformatf("pslverr on read 0x%02h", a), err, 1'b0);
  endtask

  task automatic run_row(input int i);
    row_t      row;
    apb_data_t rd;
    logic      err;
    int        errs;
    row = table_row(i);
    errs = errors;
    if (row.wr)
      apb_write(row.addr, row.wdata, rd, err);
    else
      apb_read(row.addr, rd, err);
    check_data($sformatf("row %0d prdata", i), rd, apb_data_t'(row.exp_data));
    check_bit($sformatf("row %0d pslverr", i), err, row.exp_err);
    report_test($sformatf("table row %0d", i), errs);
  endtask

  task automatic run_round(input int r);
    gpio_pins_t dir, oe, ov, tse, pins, rise;
    apb_data_t  rd;
    logic       err;
    int         errs;
    errs = errors;
    random_pins(dir);
    random_pins(oe);
    random_pins(ov);
    random_pins(tse);
    tri_state_enable = tse;
    write_ok(GPR_DIRECTION_MODE, dir);
    write_ok(GPR_OUTPUT_ENABLE, oe);
    write_ok(GPR_OUTPUT_VALUE, ov);
    read_expect(GPR_DIRECTION_MODE, dir);
    read_expect(GPR_OUTPUT_ENABLE, oe);
    read_expect(GPR_OUTPUT_VALUE, ov);
    check_pins("pin_out", pin_out, ov);
    check_pins("pin_oe_n", pin_oe_n, oe_n_rule(dir, oe, tse));
    random_pins(pins);  // input sampling, held 4 cycles
    pin_in = pins;
    repeat (4) @(negedge pclk18);
    read_expect(GPR_INPUT_VALUE, pins);
    pin_in = '0;  // settle low, flush old status
    repeat (4) @(negedge pclk18);
    apb_read(GPR_INT_STATUS, rd, err);
    check_bit("pslverr on status flush", err, 1'b0);
    read_expect(GPR_INT_STATUS, '0);
    check_bit("irq after flush", irq, 1'b0);
    random_pins(rise);
    pin_in = rise;
    repeat (5) @(negedge pclk18);  // 3 sync edges plus irq flop
    check_bit("irq after rising edges", irq, |(rise & dir));
    read_expect(GPR_INT_STATUS, rise & dir);
    read_expect(GPR_INT_STATUS, '0);  // cleared by first read
    check_bit("irq after status read", irq, 1'b0);
    report_test($sformatf("random round %0d", r), errs);
  endtask

  // --------------------
  // main sequence
  initial
  begin
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    pin_in = '0;
    tri_state_enable = '0;
    n_reset18 = 1'b0;
    rng = 32'd75990;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    repeat (3) @(posedge pclk18);
    @(negedge pclk18);
    n_reset18 = 1'b1;
    check_pins("pin_oe_n after reset", pin_oe_n, '1);
    check_bit("irq after reset", irq, 1'b0);
    check_bit("pslverr after reset", pslverr, 1'b0);
    report_test("reset outputs", 0);
    for (int i = 0; i < NUM_ROWS; i++)
      run_row(i);
    check_pins("pin_out after table", pin_out, 16'hA5C3);
    check_pins("pin_oe_n after table", pin_oe_n, oe_n_rule(16'h00F0, 16'hFF0F, '0));
    for (int r = 0; r < NUM_ROUNDS; r++)
      run_round(r);
    $display("summary: %0d tests, %0d failed, %0d check errors",
             tests_run, tests_failed, errors);
    if (errors == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

  // watchdog
  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge pclk18);
    $display("timeout: test sequence did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule
